/* logic/core_pkg.sv */
//Core package
//Shared word and index types, ALU operation encoding and the RV32I
//opcode and funct field constants used by decode

package core_pkg;

//Data word and register index
typedef logic [31:0] word_t;
typedef logic [4:0]  reg_idx_t;

//ALU operations
//PASS_B forwards operand B untouched (LUI)
typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
} alu_op_e;

//Major opcodes
localparam logic [6:0] OPCODE_OP     = 7'b0110011;
localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

//funct3 codes, shared by OP and OP-IMM
localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
localparam logic [2:0] FUNCT3_SLL     = 3'b001;
localparam logic [2:0] FUNCT3_SLT     = 3'b010;
localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
localparam logic [2:0] FUNCT3_XOR     = 3'b100;
localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
localparam logic [2:0] FUNCT3_OR      = 3'b110;
localparam logic [2:0] FUNCT3_AND     = 3'b111;

//Legal funct7 values
//ALT selects SUB and SRA
localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

endpackage : core_pkg

/* logic/core_rf.sv */
//Core register file
//32 x 32 bit, two combinational read ports and one write port
//x0 reads as zero and ignores writes

module core_rf (
    //Clock and reset
    input  logic               i_clk,
    input  logic               i_reset,

    //rd write port
    input  core_pkg::reg_idx_t i_rd_idx,
    input  core_pkg::word_t    i_rd_wdata,
    input  logic               i_rd_wen,

    //rs1 read port
    input  core_pkg::reg_idx_t i_rs1_idx,
    output core_pkg::word_t    o_rs1_rdata,

    //rs2 read port
    input  core_pkg::reg_idx_t i_rs2_idx,
    output core_pkg::word_t    o_rs2_rdata
);

import core_pkg::*;

//Only x1..x31 have storage
word_t regs [31:1];

//Write at the edge, all registers cleared on reset
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (i_rd_wen && (i_rd_idx != '0)) begin
        regs[i_rd_idx] <= i_rd_wdata;
    end
end

//Asynchronous reads, index zero is hardwired
assign o_rs1_rdata = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
assign o_rs2_rdata = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

endmodule : core_rf

/* logic/core_stage_d.sv */
//Decode stage
//Parses OP, OP-IMM and LUI, picks operands from the register file or the
//bypass, and registers the decoded operation for execute

module core_stage_d (
    //Clock and reset
    input  logic                i_clk,
    input  logic                i_reset,

    //Instruction in
    input  logic                i_instr_valid,
    input  core_pkg::word_t     i_instr,

    //Register file reads
    output core_pkg::reg_idx_t  o_rs1_idx,
    output core_pkg::reg_idx_t  o_rs2_idx,
    input  core_pkg::word_t     i_rs1_rdata,
    input  core_pkg::word_t     i_rs2_rdata,

    //Bypass
    input  logic                i_bypass_rs1,
    input  core_pkg::word_t     i_bypass_rs1_data,
    input  logic                i_bypass_rs2,
    input  core_pkg::word_t     i_bypass_rs2_data,

    //To E
    output logic                o_d_valid,
    output logic                o_d_illegal,
    output core_pkg::alu_op_e   o_d_alu_op,
    output core_pkg::reg_idx_t  o_d_rd,
    output core_pkg::word_t     o_d_op_a,
    output core_pkg::word_t     o_d_op_b
);

import core_pkg::*;

//Instruction fields
logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
reg_idx_t   rd;
assign opcode = i_instr[6:0];
assign rd     = i_instr[11:7];
assign funct3 = i_instr[14:12];
assign funct7 = i_instr[31:25];

//Immediates
word_t imm_i;
word_t imm_shamt;
word_t imm_u;
assign imm_i     = {{20{i_instr[31]}}, i_instr[31:20]};
assign imm_shamt = {27'd0, i_instr[24:20]};
assign imm_u     = {i_instr[31:12], 12'd0};

//Source indices go straight to the RF and the bypass
assign o_rs1_idx = i_instr[19:15];
assign o_rs2_idx = i_instr[24:20];

//Opcode group
logic is_op;
logic is_op_imm;
logic is_lui;
logic is_shift;
assign is_op     = (opcode == OPCODE_OP);
assign is_op_imm = (opcode == OPCODE_OP_IMM);
assign is_lui    = (opcode == OPCODE_LUI);
assign is_shift  = (funct3 == FUNCT3_SLL) || (funct3 == FUNCT3_SRL_SRA);

//Decode the operation and check the encoding
alu_op_e alu_op;
logic    illegal;
always_comb begin
    alu_op  = ALU_ADD;
    illegal = 1'b0;
    case (funct3)
        FUNCT3_ADD_SUB: begin
            //ADDI has no SUB form
            if (is_op && (funct7 == FUNCT7_ALT)) begin
                alu_op = ALU_SUB;
            end else begin
                alu_op = ALU_ADD;
            end
        end
        FUNCT3_SLL:     alu_op = ALU_SLL;
        FUNCT3_SLT:     alu_op = ALU_SLT;
        FUNCT3_SLTU:    alu_op = ALU_SLTU;
        FUNCT3_XOR:     alu_op = ALU_XOR;
        FUNCT3_SRL_SRA: begin
            if (funct7 == FUNCT7_ALT) begin
                alu_op = ALU_SRA;
            end else begin
                alu_op = ALU_SRL;
            end
        end
        FUNCT3_OR:      alu_op = ALU_OR;
        default:        alu_op = ALU_AND;
    endcase

    if (is_op) begin
        //Only BASE or ALT, and ALT only for SUB and SRA
        if ((funct7 != FUNCT7_BASE) && (funct7 != FUNCT7_ALT)) begin
            illegal = 1'b1;
        end else if ((funct7 == FUNCT7_ALT) && !(funct3 == FUNCT3_ADD_SUB ||
                     funct3 == FUNCT3_SRL_SRA)) begin
            illegal = 1'b1;
        end
    end else if (is_op_imm) begin
        //Immediate shifts: upper bits must be standard
        if ((funct3 == FUNCT3_SLL) && (funct7 != FUNCT7_BASE)) begin
            illegal = 1'b1;
        end else if ((funct3 == FUNCT3_SRL_SRA) && (funct7 != FUNCT7_BASE) &&
                     (funct7 != FUNCT7_ALT)) begin
            illegal = 1'b1;
        end
    end else if (is_lui) begin
        alu_op = ALU_PASS_B;
    end else begin
        illegal = 1'b1;
    end
end

//Source values, bypass wins over the RF
word_t rs1_val;
word_t rs2_val;
assign rs1_val = i_bypass_rs1 ? i_bypass_rs1_data : i_rs1_rdata;
assign rs2_val = i_bypass_rs2 ? i_bypass_rs2_data : i_rs2_rdata;

//Operand mux
word_t op_a;
word_t op_b;
always_comb begin
    op_a = is_lui ? '0 : rs1_val;
    if (is_op) begin
        op_b = rs2_val;
    end else if (is_lui) begin
        op_b = imm_u;
    end else if (is_op_imm && is_shift) begin
        op_b = imm_shamt;
    end else begin
        op_b = imm_i;
    end
end

//Control registers
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        o_d_valid   <= 1'b0;
        o_d_illegal <= 1'b0;
    end else begin
        o_d_valid   <= i_instr_valid;
        o_d_illegal <= i_instr_valid && illegal;
    end
end

//Payload registers
//Illegal instructions carry all zeros
always_ff @(posedge i_clk) begin
    o_d_alu_op <= alu_op;
    o_d_rd     <= illegal ? '0 : rd;
    o_d_op_a   <= illegal ? '0 : op_a;
    o_d_op_b   <= illegal ? '0 : op_b;
end

endmodule : core_stage_d

/* logic/core_stage_e.sv */
//Execute stage
//ALU for the OP, OP-IMM and LUI subset plus the output register that
//feeds the register file write and the retire port

module core_stage_e (
    //Clock and reset
    input  logic                i_clk,
    input  logic                i_reset,

    //From D
    input  logic                i_d_valid,
    input  logic                i_d_illegal,
    input  core_pkg::alu_op_e   i_d_alu_op,
    input  core_pkg::reg_idx_t  i_d_rd,
    input  core_pkg::word_t     i_d_op_a,
    input  core_pkg::word_t     i_d_op_b,

    //Combinational result for forwarding
    output logic                o_e_wen,
    output core_pkg::reg_idx_t  o_e_rd,
    output core_pkg::word_t     o_e_result,

    //Output register, to writeback and retire
    output logic                o_w_valid,
    output logic                o_w_illegal,
    output core_pkg::reg_idx_t  o_w_rd,
    output core_pkg::word_t     o_w_wdata
);

import core_pkg::*;

//Shift amount is the low five bits of B
logic [4:0] shamt;
assign shamt = i_d_op_b[4:0];

//ALU
word_t alu_result;
always_comb begin
    case (i_d_alu_op)
        ALU_ADD:    alu_result = i_d_op_a + i_d_op_b;
        ALU_SUB:    alu_result = i_d_op_a - i_d_op_b;
        ALU_SLL:    alu_result = i_d_op_a << shamt;
        ALU_SLT: begin
            //Signed compare
            alu_result = {31'd0, $signed(i_d_op_a) < $signed(i_d_op_b)};
        end
        ALU_SLTU: begin
            //Unsigned compare
            alu_result = {31'd0, i_d_op_a < i_d_op_b};
        end
        ALU_XOR:    alu_result = i_d_op_a ^ i_d_op_b;
        ALU_SRL:    alu_result = i_d_op_a >> shamt;
        ALU_SRA: begin
            //Arithmetic shift keeps the sign
            alu_result = word_t'($signed(i_d_op_a) >>> shamt);
        end
        ALU_OR:     alu_result = i_d_op_a | i_d_op_b;
        ALU_AND:    alu_result = i_d_op_a & i_d_op_b;
        ALU_PASS_B: alu_result = i_d_op_b;
        default:    alu_result = '0;
    endcase
end

//Illegal instructions produce zero
word_t e_result;
assign e_result = i_d_illegal ? '0 : alu_result;

//Forwarding view of E
//No write for bubbles, illegal ops or rd zero
assign o_e_wen    = i_d_valid && !i_d_illegal && (i_d_rd != '0);
assign o_e_rd     = i_d_rd;
assign o_e_result = e_result;

//Output register, control
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        o_w_valid   <= 1'b0;
        o_w_illegal <= 1'b0;
    end else begin
        o_w_valid   <= i_d_valid;
        o_w_illegal <= i_d_valid && i_d_illegal;
    end
end

//Output register, payload
always_ff @(posedge i_clk) begin
    o_w_rd    <= i_d_rd;
    o_w_wdata <= e_result;
end

endmodule : core_stage_e

/* logic/core_bypass.sv */
//Bypass unit
//Forwards results not yet in the register file back into decode
//E is younger than writeback and wins

module core_bypass (
    //Decode sources
    input  core_pkg::reg_idx_t i_rs1_idx,
    input  core_pkg::reg_idx_t i_rs2_idx,

    //E stage destination, combinational result
    input  logic               i_e_wen,
    input  core_pkg::reg_idx_t i_e_rd,
    input  core_pkg::word_t    i_e_result,

    //Writeback destination, being written this cycle
    input  logic               i_w_wen,
    input  core_pkg::reg_idx_t i_w_rd,
    input  core_pkg::word_t    i_w_wdata,

    //To decode
    output logic               o_bypass_rs1,
    output core_pkg::word_t    o_bypass_rs1_data,
    output logic               o_bypass_rs2,
    output core_pkg::word_t    o_bypass_rs2_data
);

import core_pkg::*;

//Select for one source
//Returns {hit, data}, youngest match first
function automatic logic [32:0] fwd_sel(
    input reg_idx_t src,
    input logic     e_wen,
    input reg_idx_t e_rd,
    input word_t    e_data,
    input logic     w_wen,
    input reg_idx_t w_rd,
    input word_t    w_data
);
    logic [32:0] sel;
    sel = {1'b0, 32'd0};
    //x0 always comes from the RF
    if (src != '0) begin
        if (e_wen && (e_rd == src)) begin
            //Distance one
            sel = {1'b1, e_data};
        end else if (w_wen && (w_rd == src)) begin
            //Distance two, RF write still pending
            sel = {1'b1, w_data};
        end
    end
    return sel;
endfunction

assign {o_bypass_rs1, o_bypass_rs1_data} = fwd_sel(i_rs1_idx, i_e_wen, i_e_rd, i_e_result,
                                                   i_w_wen, i_w_rd, i_w_wdata);
assign {o_bypass_rs2, o_bypass_rs2_data} = fwd_sel(i_rs2_idx, i_e_wen, i_e_rd, i_e_result,
                                                   i_w_wen, i_w_rd, i_w_wdata);

endmodule : core_bypass

/* logic/core_top.sv */
//Core top
//Two-stage integer pipeline (decode, execute) with register file,
//bypass unit and a retire port fed by the execute output register

module core_top (
    //Clock and reset
    input  logic               i_clk,
    input  logic               i_reset,

    //Instruction in
    input  logic               i_instr_valid,
    input  core_pkg::word_t    i_instr,

    //Retire
    output logic               o_retire_valid,
    output core_pkg::reg_idx_t o_retire_rd,
    output core_pkg::word_t    o_retire_wdata,
    output logic               o_retire_illegal
);

import core_pkg::*;

//RF read ports
reg_idx_t rs1_idx;
word_t    rs1_rdata;
reg_idx_t rs2_idx;
word_t    rs2_rdata;

//D to E
logic     d_valid;
logic     d_illegal;
alu_op_e  d_alu_op;
reg_idx_t d_rd;
word_t    d_op_a;
word_t    d_op_b;

//E forwarding view
logic     e_wen;
reg_idx_t e_rd;
word_t    e_result;

//E output register
logic     w_valid;
logic     w_illegal;
reg_idx_t w_rd;
word_t    w_wdata;

//RF write enable
logic     rd_wen;

//Bypass to decode
logic     bypass_rs1;
word_t    bypass_rs1_data;
logic     bypass_rs2;
word_t    bypass_rs2_data;

//Illegal instructions write nothing
assign rd_wen = w_valid && !w_illegal;

//Retire straight from the E output register
assign o_retire_valid   = w_valid;
assign o_retire_rd      = w_rd;
assign o_retire_wdata   = w_wdata;
assign o_retire_illegal = w_illegal;

core_rf rf (
    .*,
    .i_rd_idx(w_rd),
    .i_rd_wdata(w_wdata),
    .i_rd_wen(rd_wen),
    .i_rs1_idx(rs1_idx),
    .o_rs1_rdata(rs1_rdata),
    .i_rs2_idx(rs2_idx),
    .o_rs2_rdata(rs2_rdata)
);

core_stage_d stage_d (
    .*,
    .o_rs1_idx(rs1_idx),
    .o_rs2_idx(rs2_idx),
    .i_rs1_rdata(rs1_rdata),
    .i_rs2_rdata(rs2_rdata),
    .i_bypass_rs1(bypass_rs1),
    .i_bypass_rs1_data(bypass_rs1_data),
    .i_bypass_rs2(bypass_rs2),
    .i_bypass_rs2_data(bypass_rs2_data),
    .o_d_valid(d_valid),
    .o_d_illegal(d_illegal),
    .o_d_alu_op(d_alu_op),
    .o_d_rd(d_rd),
    .o_d_op_a(d_op_a),
    .o_d_op_b(d_op_b)
);

core_stage_e stage_e (
    .*,
    .i_d_valid(d_valid),
    .i_d_illegal(d_illegal),
    .i_d_alu_op(d_alu_op),
    .i_d_rd(d_rd),
    .i_d_op_a(d_op_a),
    .i_d_op_b(d_op_b),
    .o_e_wen(e_wen),
    .o_e_rd(e_rd),
    .o_e_result(e_result),
    .o_w_valid(w_valid),
    .o_w_illegal(w_illegal),
    .o_w_rd(w_rd),
    .o_w_wdata(w_wdata)
);

//Writeback side uses the RF write enable
core_bypass bypass (
    .i_rs1_idx(rs1_idx),
    .i_rs2_idx(rs2_idx),
    .i_e_wen(e_wen),
    .i_e_rd(e_rd),
    .i_e_result(e_result),
    .i_w_wen(rd_wen),
    .i_w_rd(w_rd),
    .i_w_wdata(w_wdata),
    .o_bypass_rs1(bypass_rs1),
    .o_bypass_rs1_data(bypass_rs1_data),
    .o_bypass_rs2(bypass_rs2),
    .o_bypass_rs2_data(bypass_rs2_data)
);

endmodule : core_top

/* verification/core_checker.sv */
//Retire checker
//Bound into core_top, watches retire latency, reset state and the
//shape of illegal retires

module core_checker (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_instr_valid,
    input  logic               i_retire_valid,
    input  core_pkg::reg_idx_t i_retire_rd,
    input  core_pkg::word_t    i_retire_wdata,
    input  logic               i_retire_illegal
);

//Failure count, read by the testbench
int violations = 0;

//Edges seen with reset low, saturates at two
logic [1:0] settled = 2'b00;
always @(posedge i_clk) begin
    if (i_reset) begin
        settled <= 2'b00;
    end else begin
        settled <= {settled[0], 1'b1};
    end
end

//Sampled at edge N, retired in the cycle after edge N+1
retire_latency: assert property (@(posedge i_clk)
    settled[1] |-> (i_retire_valid == $past(i_instr_valid, 2)))
    else begin
        $error("retire valid does not follow instruction valid by two edges");
        violations++;
    end

//Pipeline empty right after a reset edge
reset_quiet: assert property (@(posedge i_clk)
    i_reset |=> (!i_retire_valid && !i_retire_illegal))
    else begin
        $error("retire output active after a reset edge");
        violations++;
    end

//Illegal retires carry no destination and no data
illegal_zero: assert property (@(posedge i_clk)
    (i_retire_valid && i_retire_illegal) |-> (i_retire_rd == '0 && i_retire_wdata == '0))
    else begin
        $error("illegal retire with nonzero rd or wdata");
        violations++;
    end

endmodule : core_checker

bind core_top core_checker retire_checks (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_instr_valid(i_instr_valid),
    .i_retire_valid(o_retire_valid),
    .i_retire_rd(o_retire_rd),
    .i_retire_wdata(o_retire_wdata),
    .i_retire_illegal(o_retire_illegal)
);

/* verification/core_tb.sv */
//Core testbench
//Random OP, OP-IMM, LUI and illegal stream with gaps, checked against a
//reference model of the register file in retire order

module core_tb;

import core_pkg::*;

localparam int CLK_PERIOD = 40;
//Issue slots, gaps included
localparam int N_SLOTS    = 400;

typedef struct packed {
    logic     illegal;
    reg_idx_t rd;
    word_t    value;
} expect_t;

logic     i_clk;
logic     i_reset;
logic     i_instr_valid;
word_t    i_instr;
logic     o_retire_valid;
reg_idx_t o_retire_rd;
word_t    o_retire_wdata;
logic     o_retire_illegal;

//Issued but not yet retired, oldest first
word_t    pending [$];
//Model register file, x0 stays zero
word_t    model_regs [32];
reg_idx_t last_rd = '0;

int rd_errs      = 0;
int data_errs    = 0;
int illegal_errs = 0;
int extra_errs   = 0;

core_top dut (.*);

initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
end

//Sources mostly from x0..x3 or the last destination, so dependences are common
function automatic reg_idx_t pick_src();
    int sel;
    sel = $urandom_range(0, 7);
    if (sel < 5) return reg_idx_t'($urandom_range(0, 3));
    if (sel == 5) return last_rd;
    return reg_idx_t'($urandom_range(0, 31));
endfunction

//12-bit immediates with sign edge values
function automatic logic [11:0] pick_imm();
    case ($urandom_range(0, 5))
        0: return 12'h000;
        1: return 12'h001;
        2: return 12'h7ff;
        3: return 12'h800;
        4: return 12'hfff;
        default: return 12'($urandom);
    endcase
endfunction

//One random instruction, kinds 13..15 are illegal
function automatic word_t make_instr();
    int         kind;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [6:0] opc;
    logic [11:0] imm;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    kind = $urandom_range(0, 15);
    f3   = 3'($urandom_range(0, 7));
    rd   = ($urandom_range(0, 3) == 0) ? reg_idx_t'($urandom) : reg_idx_t'($urandom_range(0, 3));
    rs1  = pick_src();
    rs2  = pick_src();
    if (kind < 6) begin
        f7 = FUNCT7_BASE;
        if ((f3 == FUNCT3_ADD_SUB || f3 == FUNCT3_SRL_SRA) && $urandom_range(0, 1) == 1) begin
            f7 = FUNCT7_ALT;
        end
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    end else if (kind < 11) begin
        imm = pick_imm();
        //Shift forms need standard upper bits
        if (f3 == FUNCT3_SLL) begin
            imm[11:5] = FUNCT7_BASE;
        end else if (f3 == FUNCT3_SRL_SRA) begin
            imm[11:5] = ($urandom_range(0, 1) == 1) ? FUNCT7_ALT : FUNCT7_BASE;
        end
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    end else if (kind < 13) begin
        case ($urandom_range(0, 4))
            0: return {20'h80000, rd, OPCODE_LUI};
            1: return {20'h7ffff, rd, OPCODE_LUI};
            2: return {20'hfffff, rd, OPCODE_LUI};
            default: return {20'($urandom), rd, OPCODE_LUI};
        endcase
    end else if (kind == 13) begin
        opc = 7'($urandom);
        if (opc == OPCODE_OP || opc == OPCODE_OP_IMM || opc == OPCODE_LUI) opc = 7'h7f;
        return {25'($urandom), opc};
    end else if (kind == 14) begin
        //Bad funct7, or ALT on a function without an alternate form
        f7 = 7'($urandom);
        if (f7 == FUNCT7_BASE || f7 == FUNCT7_ALT) f7 = 7'b0100001;
        if ($urandom_range(0, 1) == 1) begin
            f7 = FUNCT7_ALT;
            if (f3 == FUNCT3_ADD_SUB || f3 == FUNCT3_SRL_SRA) f3 = FUNCT3_XOR;
        end
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    end
    //Immediate shift with nonstandard upper bits
    f3 = ($urandom_range(0, 1) == 1) ? FUNCT3_SLL : FUNCT3_SRL_SRA;
    f7 = 7'($urandom);
    if (f7 == FUNCT7_BASE || f7 == FUNCT7_ALT) f7 = 7'b0000010;
    return {f7, rs2, rs1, f3, rd, OPCODE_OP_IMM};
endfunction

//Expected retire for one instruction against the model registers
function automatic expect_t predict_retire(input word_t instr, input word_t regs [32]);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [4:0] sh;
    word_t      a;
    word_t      b;
    expect_t    res;
    opc = instr[6:0];
    f3  = instr[14:12];
    f7  = instr[31:25];
    a   = regs[instr[19:15]];
    b   = '0;
    res = '{illegal: 1'b0, rd: instr[11:7], value: '0};
    case (opc)
        OPCODE_OP: begin
            b = regs[instr[24:20]];
            if (f7 != FUNCT7_BASE && f7 != FUNCT7_ALT) res.illegal = 1'b1;
            if (f7 == FUNCT7_ALT && f3 != FUNCT3_ADD_SUB && f3 != FUNCT3_SRL_SRA) begin
                res.illegal = 1'b1;
            end
        end
        OPCODE_OP_IMM: begin
            b = {{20{instr[31]}}, instr[31:20]};
            if (f3 == FUNCT3_SLL && f7 != FUNCT7_BASE) res.illegal = 1'b1;
            if (f3 == FUNCT3_SRL_SRA && f7 != FUNCT7_BASE && f7 != FUNCT7_ALT) begin
                res.illegal = 1'b1;
            end
        end
        OPCODE_LUI: b = {instr[31:12], 12'd0};
        default:    res.illegal = 1'b1;
    endcase
    sh = b[4:0];
    if (res.illegal) begin
        res.rd = '0;
    end else if (opc == OPCODE_LUI) begin
        res.value = b;
    end else begin
        case (f3)
            FUNCT3_ADD_SUB: res.value = (opc == OPCODE_OP && f7 == FUNCT7_ALT) ? a - b : a + b;
            FUNCT3_SLL:     res.value = a << sh;
            //Different signs decide by the sign of a
            FUNCT3_SLT:     res.value = (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            FUNCT3_SLTU:    res.value = word_t'(a < b);
            FUNCT3_XOR:     res.value = a ^ b;
            FUNCT3_SRL_SRA: begin
                res.value = a >> sh;
                //Fill the vacated top bits with the sign
                if (f7 == FUNCT7_ALT && a[31]) res.value = res.value | ~(32'hffffffff >> sh);
            end
            FUNCT3_OR:      res.value = a | b;
            default:        res.value = a & b;
        endcase
    end
    return res;
endfunction

//Stimulus, then drain and final verdict
initial begin : drive
    word_t instr;
    int    total;
    i_reset       = 1'b1;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    void'($urandom(32'h2f5d));
    foreach (model_regs[i]) model_regs[i] = '0;
    repeat (2) @(posedge i_clk);
    i_reset <= 1'b0;
    for (int slot = 0; slot < N_SLOTS; slot++) begin
        if ($urandom_range(0, 7) == 0) begin
            //Gap, payload is junk
            i_instr_valid <= 1'b0;
            i_instr       <= word_t'($urandom);
        end else begin
            instr = make_instr();
            i_instr_valid <= 1'b1;
            i_instr       <= instr;
            pending.push_back(instr);
            last_rd = instr[11:7];
        end
        @(posedge i_clk);
    end
    i_instr_valid <= 1'b0;
    while (pending.size() != 0) @(negedge i_clk);
    //A few more cycles to catch stray retires
    repeat (3) @(negedge i_clk);
    total = rd_errs + data_errs + illegal_errs + extra_errs + dut.retire_checks.violations;
    $display("Errors: rd %0d, data %0d, illegal %0d, unexpected retire %0d, assertion %0d",
             rd_errs, data_errs, illegal_errs, extra_errs, dut.retire_checks.violations);
    if (total == 0) begin
        $display("Everything OK");
    end else begin
        $display("Something failed");
    end
    $finish;
end

//Compare retires in issue order, sampled mid-cycle
initial begin : compare
    word_t   instr;
    expect_t want;
    forever begin
        @(negedge i_clk);
        if (o_retire_valid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("Retire pulse at time %0t with no instruction outstanding", $time);
                extra_errs++;
            end else begin
                instr = pending.pop_front();
                want  = predict_retire(instr, model_regs);
                assert (o_retire_illegal == want.illegal) else begin
                    $display("ERR %0t: illegal flag for %h expected %0b got %0b",
                             $time, instr, want.illegal, o_retire_illegal);
                    illegal_errs++;
                end
                assert (o_retire_rd == want.rd) else begin
                    $display("ERR %0t: rd for %h expected %0d got %0d",
                             $time, instr, want.rd, o_retire_rd);
                    rd_errs++;
                end
                assert (o_retire_wdata == want.value) else begin
                    $display("ERR %0t: wdata for %h expected %h got %h",
                             $time, instr, want.value, o_retire_wdata);
                    data_errs++;
                end
                if (!want.illegal && want.rd != '0) model_regs[want.rd] = want.value;
            end
        end
    end
end

//Watchdog
initial begin : watchdog
    #((N_SLOTS + 20) * CLK_PERIOD);
    $display("Timeout: %0d instructions still waiting to retire", pending.size());
    $display("Something failed");
    $finish;
end

endmodule : core_tb

/* flist.f */
logic/core_pkg.sv
logic/core_rf.sv
logic/core_stage_d.sv
logic/core_stage_e.sv
logic/core_bypass.sv
logic/core_top.sv
verification/core_checker.sv
verification/core_tb.sv
